// ==== Bender.yml ====
package:
  name: tbmem

sources:
  # design, package first
  - logic/tbmem_pkg.sv
  - logic/tbmem_req_decoder.sv
  - logic/sram_slice.sv
  - logic/tbmem_virt_periph.sv
  - logic/tbmem_rsp_merge.sv
  - logic/tbmem_top.sv

  # testbench
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/tbmem_tb.sv

// ==== flist.f ====
logic/tbmem_pkg.sv
logic/tbmem_req_decoder.sv
logic/sram_slice.sv
logic/tbmem_virt_periph.sv
logic/tbmem_rsp_merge.sv
logic/tbmem_top.sv
verif/tb_clk_gen.sv
verif/tbmem_tb.sv

// ==== logic/sram_slice.sv ====
// 64-bit SRAM slice
`timescale 1ns/10ps
`default_nettype none

module sram_slice (
  input  wire logic                                   Clk_CI,
  input  wire logic                                   cs_i,
  input  wire logic                                   we_i,
  input  wire logic [tbmem_pkg::word_addr_width-1:0]  addr_i,
  input  wire logic [tbmem_pkg::slice_width-1:0]      wdata_i,
  input  wire logic [tbmem_pkg::slice_width/8-1:0]    be_i,
  output logic      [tbmem_pkg::slice_width-1:0]      rdata_o
);

  // bytes per slice word
  localparam int num_bytes = tbmem_pkg::slice_width / 8;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // contents are undefined until written
  logic [tbmem_pkg::slice_width-1:0] mem_q [tbmem_pkg::num_words];

  // read register, holds the last addressed word
  logic [tbmem_pkg::slice_width-1:0] rdata_q;

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  // byte lanes with a low enable keep their old value
  always_ff @(posedge Clk_CI) begin
    if (cs_i && we_i) begin
      for (int b = 0; b < num_bytes; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////

  // any selected access registers the addressed word
  // old contents are returned on a write, the merger ignores them
  always_ff @(posedge Clk_CI) begin
    if (cs_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule : sram_slice

`default_nettype wire

// ==== logic/tbmem_pkg.sv ====
// Testbench memory shared definitions
`default_nettype none

package tbmem_pkg;

  ////////////////////////////////////////
  // data path widths
  ////////////////////////////////////////

  // full request and response word
  localparam int data_width = 128;
  // one sram slice carries a 64-bit lane
  localparam int slice_width = 64;
  // number of slices side by side
  localparam int num_slices = data_width / slice_width;
  // one enable bit per byte of the word
  localparam int be_width = data_width / 8;

  ////////////////////////////////////////
  // memory geometry
  ////////////////////////////////////////

  // depth in words, same for every slice
  localparam int num_words = 1024;
  localparam int word_addr_width = $clog2(num_words);
  // low byte address bits inside a 16-byte word
  localparam int byte_offset_bits = $clog2(be_width);

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // memory window is 16 KiB starting at the base
  // bits 31..mem_window_bits must match the base
  localparam logic [31:0] mem_base = 32'h8000_0000;
  localparam int mem_window_bits = byte_offset_bits + word_addr_width;

  // virtual peripheral addresses, exact match only
  localparam logic [31:0] mmaddr_print = 32'h5000_0000;
  localparam logic [31:0] mmaddr_test_status = 32'h6000_0000;
  localparam logic [31:0] mmaddr_exit = 32'h6000_0004;

  ////////////////////////////////////////
  // test status magic values
  ////////////////////////////////////////

  // software writes these to report its verdict
  localparam logic [31:0] status_pass_value = 32'd123456789;
  localparam logic [31:0] status_fail_value = 32'd1;

endpackage : tbmem_pkg

`default_nettype wire

// ==== logic/tbmem_req_decoder.sv ====
// Request address decoder
`timescale 1ns/10ps
`default_nettype none

module tbmem_req_decoder (
  input  wire logic                                     req_i,
  input  wire logic                                     we_i,
  input  wire logic [31:0]                              addr_i,
  input  wire logic [tbmem_pkg::data_width-1:0]         wdata_i,
  input  wire logic [tbmem_pkg::be_width-1:0]           be_i,
  output logic      [tbmem_pkg::num_slices-1:0]         slice_cs_o,
  output logic                                          slice_we_o,
  output logic      [tbmem_pkg::word_addr_width-1:0]    slice_addr_o,
  output logic      [tbmem_pkg::data_width-1:0]         slice_wdata_o,
  output logic      [tbmem_pkg::be_width-1:0]           slice_be_o,
  output logic                                          print_wr_o,
  output logic                                          status_wr_o,
  output logic                                          exit_wr_o,
  output logic      [31:0]                              periph_wdata_o,
  output logic                                          rd_issue_o,
  output logic                                          rd_from_mem_o
);

  // address falls inside the memory window
  logic mem_hit;
  // request is a write this cycle
  logic wr_req;

  ////////////////////////////////////////
  // address classification
  ////////////////////////////////////////

  // compare only the bits above the window
  assign mem_hit = (addr_i[31:tbmem_pkg::mem_window_bits] ==
                    tbmem_pkg::mem_base[31:tbmem_pkg::mem_window_bits]);

  assign wr_req = req_i & we_i;

  ////////////////////////////////////////
  // slice side
  ////////////////////////////////////////

  // all slices are hit together, each serves one 64-bit lane
  assign slice_cs_o = {tbmem_pkg::num_slices{req_i & mem_hit}};
  assign slice_we_o = we_i;

  // drop the byte offset, keep the word index inside the window
  assign slice_addr_o = addr_i[tbmem_pkg::byte_offset_bits +: tbmem_pkg::word_addr_width];

  // lane k of data and enables belongs to slice k
  assign slice_wdata_o = wdata_i;
  assign slice_be_o = be_i;

  ////////////////////////////////////////
  // peripheral side
  ////////////////////////////////////////

  // strobes only on writes with an exact address match
  assign print_wr_o = wr_req & (addr_i == tbmem_pkg::mmaddr_print);
  assign status_wr_o = wr_req & (addr_i == tbmem_pkg::mmaddr_test_status);
  assign exit_wr_o = wr_req & (addr_i == tbmem_pkg::mmaddr_exit);

  // peripherals only look at the low 32 bits
  assign periph_wdata_o = wdata_i[31:0];

  ////////////////////////////////////////
  // read tracking for the merger
  ////////////////////////////////////////

  // every read gets a response, mapped or not
  assign rd_issue_o = req_i & ~we_i;
  // tag the read so the merger knows whether slice data is valid
  assign rd_from_mem_o = rd_issue_o & mem_hit;

endmodule : tbmem_req_decoder

`default_nettype wire

// ==== logic/tbmem_rsp_merge.sv ====
// Read response merger
`timescale 1ns/10ps
`default_nettype none

module tbmem_rsp_merge (
  input  wire logic                                Clk_CI,
  input  wire logic                                rstn_i,
  input  wire logic                                rd_issue_i,
  input  wire logic                                rd_from_mem_i,
  input  wire logic [tbmem_pkg::data_width-1:0]    slice_rdata_i,
  output logic                                     rvalid_o,
  output logic      [tbmem_pkg::data_width-1:0]    rdata_o
);

  // read accepted last cycle
  logic rvalid_q;
  // last cycle's read hit the memory window
  logic mem_tag_q;

  ////////////////////////////////////////
  // one-cycle read tracking
  ////////////////////////////////////////

  // a new read can be issued while the previous one returns
  always_ff @(posedge Clk_CI or negedge rstn_i) begin
    if (!rstn_i) begin
      rvalid_q <= 1'b0;
      mem_tag_q <= 1'b0;
    end else begin
      rvalid_q <= rd_issue_i;
      mem_tag_q <= rd_from_mem_i;
    end
  end

  ////////////////////////////////////////
  // response assembly
  ////////////////////////////////////////

  assign rvalid_o = rvalid_q;

  // slices already sit in lane order, zero for misses
  // slice registers hold stale data when the read missed memory
  assign rdata_o = mem_tag_q ? slice_rdata_i : '0;

endmodule : tbmem_rsp_merge

`default_nettype wire

// ==== logic/tbmem_top.sv ====
// Testbench memory top level
`timescale 1ns/10ps
`default_nettype none

module tbmem_top (
  input  wire logic                              Clk_CI,
  input  wire logic                              rstn_i,
  input  wire logic                              req_i,
  input  wire logic                              we_i,
  input  wire logic [31:0]                       addr_i,
  input  wire logic [tbmem_pkg::data_width-1:0]  wdata_i,
  input  wire logic [tbmem_pkg::be_width-1:0]    be_i,
  output logic                                   rvalid_o,
  output logic      [tbmem_pkg::data_width-1:0]  rdata_o,
  output logic                                   print_valid_o,
  output logic      [7:0]                        print_char_o,
  output logic                                   tests_passed_o,
  output logic                                   tests_failed_o,
  output logic                                   exit_valid_o,
  output logic      [31:0]                       exit_value_o
);

  // slice lane widths
  localparam int lane_bytes = tbmem_pkg::slice_width / 8;

  // decoder to slices
  logic [tbmem_pkg::num_slices-1:0]      slice_cs;
  logic                                  slice_we;
  logic [tbmem_pkg::word_addr_width-1:0] slice_addr;
  logic [tbmem_pkg::data_width-1:0]      slice_wdata;
  logic [tbmem_pkg::be_width-1:0]        slice_be;
  // slices to merger, lane k at bits k*64
  logic [tbmem_pkg::data_width-1:0]      slice_rdata;
  // decoder to peripherals
  logic                                  print_wr;
  logic                                  status_wr;
  logic                                  exit_wr;
  logic [31:0]                           periph_wdata;
  // decoder to merger
  logic                                  rd_issue;
  logic                                  rd_from_mem;

  ////////////////////////////////////////
  // front end
  ////////////////////////////////////////

  tbmem_req_decoder i_req_decoder (
    .req_i          ( req_i        ),
    .we_i           ( we_i         ),
    .addr_i         ( addr_i       ),
    .wdata_i        ( wdata_i      ),
    .be_i           ( be_i         ),
    .slice_cs_o     ( slice_cs     ),
    .slice_we_o     ( slice_we     ),
    .slice_addr_o   ( slice_addr   ),
    .slice_wdata_o  ( slice_wdata  ),
    .slice_be_o     ( slice_be     ),
    .print_wr_o     ( print_wr     ),
    .status_wr_o    ( status_wr    ),
    .exit_wr_o      ( exit_wr      ),
    .periph_wdata_o ( periph_wdata ),
    .rd_issue_o     ( rd_issue     ),
    .rd_from_mem_o  ( rd_from_mem  )
  );

  ////////////////////////////////////////
  // memory slices
  ////////////////////////////////////////

  for (genvar k = 0; k < tbmem_pkg::num_slices; k++) begin : gen_slice
    // each slice owns one 64-bit lane and its 8 enables
    sram_slice i_sram_slice (
      .Clk_CI  ( Clk_CI                                                  ),
      .cs_i    ( slice_cs[k]                                             ),
      .we_i    ( slice_we                                                ),
      .addr_i  ( slice_addr                                              ),
      .wdata_i ( slice_wdata[k*tbmem_pkg::slice_width +: tbmem_pkg::slice_width] ),
      .be_i    ( slice_be[k*lane_bytes +: lane_bytes]                    ),
      .rdata_o ( slice_rdata[k*tbmem_pkg::slice_width +: tbmem_pkg::slice_width] )
    );
  end

  ////////////////////////////////////////
  // peripherals and response
  ////////////////////////////////////////

  tbmem_virt_periph i_virt_periph (
    .Clk_CI         ( Clk_CI         ),
    .rstn_i         ( rstn_i         ),
    .print_wr_i     ( print_wr       ),
    .status_wr_i    ( status_wr      ),
    .exit_wr_i      ( exit_wr        ),
    .wdata_i        ( periph_wdata   ),
    .print_valid_o  ( print_valid_o  ),
    .print_char_o   ( print_char_o   ),
    .tests_passed_o ( tests_passed_o ),
    .tests_failed_o ( tests_failed_o ),
    .exit_valid_o   ( exit_valid_o   ),
    .exit_value_o   ( exit_value_o   )
  );

  tbmem_rsp_merge i_rsp_merge (
    .Clk_CI        ( Clk_CI      ),
    .rstn_i        ( rstn_i      ),
    .rd_issue_i    ( rd_issue    ),
    .rd_from_mem_i ( rd_from_mem ),
    .slice_rdata_i ( slice_rdata ),
    .rvalid_o      ( rvalid_o    ),
    .rdata_o       ( rdata_o     )
  );

endmodule : tbmem_top

`default_nettype wire

// ==== logic/tbmem_virt_periph.sv ====
// Virtual peripherals
`timescale 1ns/10ps
`default_nettype none

module tbmem_virt_periph (
  input  wire logic        Clk_CI,
  input  wire logic        rstn_i,
  input  wire logic        print_wr_i,
  input  wire logic        status_wr_i,
  input  wire logic        exit_wr_i,
  input  wire logic [31:0] wdata_i,
  output logic             print_valid_o,
  output logic      [7:0]  print_char_o,
  output logic             tests_passed_o,
  output logic             tests_failed_o,
  output logic             exit_valid_o,
  output logic      [31:0] exit_value_o
);

  // status write carries one of the magic values
  logic is_pass;
  logic is_fail;

  assign is_pass = (wdata_i == tbmem_pkg::status_pass_value);
  assign is_fail = (wdata_i == tbmem_pkg::status_fail_value);

  ////////////////////////////////////////
  // print port
  ////////////////////////////////////////

  // one-cycle strobe, char stays until the next print
  always_ff @(posedge Clk_CI or negedge rstn_i) begin
    if (!rstn_i) begin
      print_valid_o <= 1'b0;
      print_char_o <= '0;
    end else begin
      print_valid_o <= print_wr_i;
      if (print_wr_i) begin
        print_char_o <= wdata_i[7:0];
      end
    end
  end

  ////////////////////////////////////////
  // test status
  ////////////////////////////////////////

  // flags are sticky until reset, other values are ignored
  always_ff @(posedge Clk_CI or negedge rstn_i) begin
    if (!rstn_i) begin
      tests_passed_o <= 1'b0;
      tests_failed_o <= 1'b0;
    end else if (status_wr_i) begin
      if (is_pass) tests_passed_o <= 1'b1;
      if (is_fail) tests_failed_o <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // exit capture
  ////////////////////////////////////////

  // last exit write wins, valid stays up
  always_ff @(posedge Clk_CI or negedge rstn_i) begin
    if (!rstn_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else if (exit_wr_i) begin
      exit_valid_o <= 1'b1;
      exit_value_o <= wdata_i;
    end
  end

endmodule : tbmem_virt_periph

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_ns = 8,
  parameter int reset_cycles = 5
) (
  output logic clk_o,
  output logic rstn_o
);

  // free running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // power-on reset, released on a falling edge
  initial begin
    rstn_o = 1'b0;
    repeat (reset_cycles) @(negedge clk_o);
    rstn_o = 1'b1;
  end

endmodule : tb_clk_gen

`default_nettype wire

// ==== verif/tbmem_tb.sv ====
// Testbench memory regression
`timescale 1ns/10ps
`default_nettype none

module tbmem_tb;

  // request cycles per test in run order size the watchdog
  // the status test counts its six reset cycles too
  localparam int test_cycles = 3 + 33 + 25 + 10 + 17 + 12;
  localparam int watchdog_ns = (test_cycles + 5) * 8 + 50 * 8;
  localparam logic [31:0] mem_base = 32'h8000_0000;
  localparam logic [31:0] unmapped_addr = 32'h4000_0000;

  logic clk, por_rstn, soft_rstn, rstn;
  logic req, we;
  logic [31:0] addr;
  logic [127:0] wdata;
  logic [15:0] be;
  logic rvalid, print_valid, tests_passed, tests_failed, exit_valid;
  logic [127:0] rdata;
  logic [7:0] print_char;
  logic [31:0] exit_value;

  // reference memory with one entry per written word index
  logic [127:0] ref_mem [int];
  // expected outputs after the rising edge that ends the last request
  logic exp_rvalid, exp_rdata_known, exp_print, exp_passed, exp_failed, exp_exit;
  logic [127:0] exp_rdata;
  logic [7:0] exp_char;
  logic [31:0] exp_exit_val;
  int n_checks, n_errors, n_rvalid, n_prints;
  logic [31:0] lfsr_q = 32'h537e_e784;
  // spread over the window with both ends included
  int test_words [8] = '{0, 1, 7, 64, 333, 512, 900, 1023};

  // soft reset lets a test restart the DUT
  assign rstn = por_rstn & soft_rstn;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rstn_o(por_rstn));

  tbmem_top i_tbmem_top (
    .Clk_CI(clk), .rstn_i(rstn), .req_i(req), .we_i(we), .addr_i(addr),
    .wdata_i(wdata), .be_i(be), .rvalid_o(rvalid), .rdata_o(rdata),
    .print_valid_o(print_valid), .print_char_o(print_char),
    .tests_passed_o(tests_passed), .tests_failed_o(tests_failed),
    .exit_valid_o(exit_valid), .exit_value_o(exit_value)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic rand_bits(input int n, output logic [127:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i] = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // 16 KiB window at the base
  function automatic logic in_window(input logic [31:0] a);
    return a[31:14] == mem_base[31:14];
  endfunction

  function automatic logic [31:0] mem_addr(input int word, input int offset);
    return mem_base + (word << 4) + offset;
  endfunction

  // bytes with a low enable keep the old value
  function automatic logic [127:0] merge_be(input logic [127:0] old_w, new_w,
                                            input logic [15:0] en);
    for (int b = 0; b < 16; b++) begin
      if (en[b]) old_w[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return old_w;
  endfunction

  task automatic check(input logic ok, input string what);
    n_checks++;
    assert (ok) else begin
      $display("Fail at %0t: %s", $time, what);
      n_errors++;
    end
  endtask

  task automatic clear_expected();
    {exp_rvalid, exp_rdata_known, exp_print, exp_passed, exp_failed, exp_exit} = '0;
    exp_rdata = '0;
    exp_char = '0;
    exp_exit_val = '0;
  endtask

  // compare every output against the prediction of the last cycle
  task automatic check_outputs();
    if (rvalid === 1'b1) n_rvalid++;
    if (print_valid === 1'b1) n_prints++;
    check(rvalid === exp_rvalid, $sformatf("rvalid %b, expected %b", rvalid, exp_rvalid));
    if (exp_rvalid && exp_rdata_known) begin
      check(rdata === exp_rdata, $sformatf("rdata %h, expected %h", rdata, exp_rdata));
    end
    check(print_valid === exp_print, $sformatf("print_valid %b, expected %b",
                                               print_valid, exp_print));
    if (exp_print) begin
      check(print_char === exp_char, $sformatf("print_char %h, expected %h",
                                               print_char, exp_char));
    end
    check({tests_passed, tests_failed, exit_valid} === {exp_passed, exp_failed, exp_exit},
          $sformatf("status flags %b%b%b, expected %b%b%b", tests_passed, tests_failed,
                    exit_valid, exp_passed, exp_failed, exp_exit));
    check(exit_value === exp_exit_val, $sformatf("exit_value %h, expected %h",
                                                 exit_value, exp_exit_val));
  endtask

  // one bus cycle checks the previous response then drives and predicts
  task automatic tick(input logic do_req, do_we, input logic [31:0] a,
                      input logic [127:0] d, input logic [15:0] en);
    int idx;
    logic is_wr;
    logic [127:0] old_w;
    @(negedge clk);
    check_outputs();
    req = do_req;
    we = do_we;
    addr = a;
    wdata = d;
    be = en;
    idx = int'(a[13:4]);
    is_wr = do_req && do_we;
    exp_rvalid = do_req && !do_we;
    exp_rdata = '0;
    exp_rdata_known = 1'b1;
    // never written words have no known value
    if (exp_rvalid && in_window(a)) begin
      exp_rdata_known = ref_mem.exists(idx);
      if (exp_rdata_known) exp_rdata = ref_mem[idx];
    end
    exp_print = is_wr && (a == tbmem_pkg::mmaddr_print);
    if (exp_print) exp_char = d[7:0];
    if (is_wr && in_window(a)) begin
      old_w = 'x;
      if (ref_mem.exists(idx)) old_w = ref_mem[idx];
      ref_mem[idx] = merge_be(old_w, d, en);
    end
    if (is_wr && a == tbmem_pkg::mmaddr_test_status) begin
      if (d[31:0] == tbmem_pkg::status_pass_value) exp_passed = 1'b1;
      if (d[31:0] == tbmem_pkg::status_fail_value) exp_failed = 1'b1;
    end
    if (is_wr && a == tbmem_pkg::mmaddr_exit) begin
      exp_exit = 1'b1;
      exp_exit_val = d[31:0];
    end
  endtask

  task automatic wr_req(input logic [31:0] a, input logic [127:0] d, input logic [15:0] en);
    tick(1'b1, 1'b1, a, d, en);
  endtask

  task automatic rd_req(input logic [31:0] a);
    tick(1'b1, 1'b0, a, '0, '0);
  endtask

  task automatic idle_cycle();
    tick(1'b0, 1'b0, '0, '0, '0);
  endtask

  // fresh reset after which memory contents count as lost
  task automatic apply_reset();
    @(negedge clk);
    soft_rstn = 1'b0;
    req = 1'b0;
    repeat (5) @(negedge clk);
    soft_rstn = 1'b1;
    clear_expected();
    ref_mem.delete();
  endtask

  task automatic report_test(input string name, input int err0);
    $display("%-14s done, %0d errors", name, n_errors - err0);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    int err0;
    err0 = n_errors;
    idle_cycle();
    check({rvalid, print_valid, tests_passed, tests_failed, exit_valid} === 5'b0 &&
          exit_value === 32'h0, "outputs not cleared by reset");
    idle_cycle();
    idle_cycle();
    report_test("reset_state", err0);
  endtask

  task automatic test_byte_enables();
    int err0;
    logic [127:0] d, e;
    err0 = n_errors;
    foreach (test_words[i]) begin
      rand_bits(128, d);
      wr_req(mem_addr(test_words[i], 0), d, '1);
    end
    foreach (test_words[i]) begin
      rand_bits(128, d);
      rand_bits(16, e);
      wr_req(mem_addr(test_words[i], 0), d, e[15:0]);
    end
    // low address bits are ignored by the word index
    foreach (test_words[i]) begin
      rd_req(mem_addr(test_words[i], i));
      idle_cycle();
    end
    idle_cycle();
    report_test("byte_enables", err0);
  endtask

  task automatic test_back_to_back();
    int err0, rv0;
    logic [127:0] d, e;
    err0 = n_errors;
    rv0 = n_rvalid;
    foreach (test_words[i]) rd_req(mem_addr(test_words[i], 0));
    // each read follows the write to its word directly
    foreach (test_words[i]) begin
      rand_bits(128, d);
      rand_bits(16, e);
      wr_req(mem_addr(test_words[i], 0), d, e[15:0]);
      rd_req(mem_addr(test_words[i], 0));
    end
    idle_cycle();
    check(n_rvalid - rv0 == 16, $sformatf("%0d read responses, expected 16", n_rvalid - rv0));
    report_test("back_to_back", err0);
  endtask

  task automatic test_print();
    int err0, p0;
    string msg;
    logic [127:0] d;
    err0 = n_errors;
    p0 = n_prints;
    msg = "tbmem ok\n";
    for (int i = 0; i < msg.len(); i++) begin
      // only the low byte prints and the upper bits are noise
      rand_bits(128, d);
      d[7:0] = msg[i];
      wr_req(tbmem_pkg::mmaddr_print, d, '1);
    end
    idle_cycle();
    check(n_prints - p0 == msg.len(), $sformatf("%0d print strobes, expected %0d",
                                                n_prints - p0, msg.len()));
    report_test("print", err0);
  endtask

  task automatic test_status_exit();
    int err0;
    logic [127:0] d;
    err0 = n_errors;
    wr_req(tbmem_pkg::mmaddr_test_status, 128'(tbmem_pkg::status_pass_value - 1), '1);
    idle_cycle();
    wr_req(tbmem_pkg::mmaddr_test_status, 128'(tbmem_pkg::status_pass_value), '1);
    idle_cycle();
    idle_cycle();
    idle_cycle();
    check(tests_passed === 1'b1, "tests_passed_o did not stay high");
    apply_reset();
    wr_req(tbmem_pkg::mmaddr_test_status, 128'(tbmem_pkg::status_fail_value), '1);
    idle_cycle();
    idle_cycle();
    check(tests_failed === 1'b1 && tests_passed === 1'b0, "tests_failed_o not set alone");
    rand_bits(128, d);
    wr_req(tbmem_pkg::mmaddr_exit, d, '1);
    idle_cycle();
    check(exit_valid === 1'b1 && exit_value === d[31:0], "exit write not captured");
    report_test("status_exit", err0);
  endtask

  task automatic test_unmapped();
    int err0, p0;
    logic [127:0] d;
    err0 = n_errors;
    rand_bits(128, d);
    wr_req(mem_addr(0, 0), d, '1);
    rand_bits(128, d);
    wr_req(mem_addr(3, 0), d, '1);
    p0 = n_prints;
    rd_req(tbmem_pkg::mmaddr_print);
    rd_req(tbmem_pkg::mmaddr_test_status);
    rd_req(tbmem_pkg::mmaddr_exit);
    rd_req(unmapped_addr);
    // aliases of words 3 and 0 outside the window and a neighbour of print
    wr_req(unmapped_addr + 32'h30, ~d, '1);
    wr_req(mem_base + 32'h4000, ~d, '1);
    wr_req(tbmem_pkg::mmaddr_print + 4, d, '1);
    rd_req(mem_addr(3, 0));
    rd_req(mem_addr(0, 0));
    idle_cycle();
    check(n_prints == p0, "unmapped write raised a print strobe");
    report_test("unmapped", err0);
  endtask

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////

  initial begin
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    be = '0;
    soft_rstn = 1'b1;
    clear_expected();
    wait (por_rstn === 1'b1);
    test_reset_state();
    test_byte_enables();
    test_back_to_back();
    test_print();
    test_status_exit();
    test_unmapped();
    $display("checks passed %0d, failed %0d", n_checks - n_errors, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // bounded by the request cycles of all tests plus margin
  initial begin
    #(watchdog_ns);
    $display("Error: watchdog expired at %0t, the tests did not finish", $time);
    $display("Regression failed");
    $finish;
  end

endmodule : tbmem_tb

`default_nettype wire
